// File: include/ps2_config.svh
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// host request-to-send timing, in system clocks.
`define PS2_INHIBIT_CYCLES 120

`define PS2_CMD_ENABLE 8'hF4 // enable data reporting.
`define PS2_ACK_BYTE   8'hFA

// screen rectangle; the smallest coordinates are zero.
`define MOUSE_X_MAX    9'd409
`define MOUSE_Y_MAX    9'd307
`define MOUSE_X_CENTER 9'd204
`define MOUSE_Y_CENTER 9'd153

`define PS2_REG_STATUS 4'h0
`define PS2_REG_POS_X  4'h4
`define PS2_REG_POS_Y  4'h8
`define PS2_REG_CTRL   4'hC

`endif

// File: rtl/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  // first byte of a standard three-byte movement packet.
  typedef struct packed {
    logic y_ovf;
    logic x_ovf;
    logic y_sign;
    logic x_sign;
    logic sync;   // always one in a well-aligned packet.
    logic middle;
    logic right;
    logic left;
  } mouse_status_t;

  // a received byte, seen either as plain data or as a status byte.
  typedef union packed {
    logic [7:0]    raw;
    mouse_status_t status;
  } mouse_byte_u;

  // one decoded packet.
  typedef struct packed {
    logic [2:0]        buttons; // middle, right, left.
    logic signed [8:0] dx;
    logic signed [8:0] dy;      // positive is upward.
  } mouse_move_t;

endpackage

`default_nettype wire

// File: rtl/ps2_byte_if.sv
`timescale 1ns/1ns
`default_nettype none

// received bytes from the frame receiver to the packet assembler.
interface ps2_byte_if;

  logic [7:0] data;
  logic       valid;      // one-cycle strobe.
  logic       parity_err;
  logic       frame_err;

  modport source (output data, output valid, output parity_err, output frame_err);

  modport sink (input data, input valid, input parity_err, input frame_err);

endinterface

`default_nettype wire

// File: rtl/ps2_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk_in,
  input  logic       ps2_data_in,
  input  logic       hold,
  output logic       clk_fall,
  output logic       data_sync,
  ps2_byte_if.source rx
);

  logic [1:0] clk_sync;
  logic [1:0] dat_sync;
  logic       clk_last;
  logic       active;
  logic [3:0] bit_cnt;     // 0 to 7 data, 8 parity, 9 stop.
  logic [7:0] shift;
  logic       parity_bit;
  logic       parity_err_q;
  logic       frame_err_q;
  logic       valid_q;

  // ***********************************************************************
  // line synchronizers and edge detect. Both lines idle high.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_last <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk_in};
      dat_sync <= {dat_sync[0], ps2_data_in};
      clk_last <= clk_sync[1];
    end
  end

  assign clk_fall  = clk_last & ~clk_sync[1];
  assign data_sync = dat_sync[1];

  // ***********************************************************************
  // frame receiver.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active  <= 1'b0;
      bit_cnt <= 4'd0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (hold) begin
        active <= 1'b0;                 // the sender owns the bus.
      end else if (clk_fall) begin
        if (!active) begin
          active  <= ~data_sync;        // a low start bit opens a frame.
          bit_cnt <= 4'd0;
        end else if (bit_cnt == 4'd9) begin
          active  <= 1'b0;
          valid_q <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && clk_fall && !hold) begin
      if (bit_cnt < 4'd8) begin
        shift <= {data_sync, shift[7:1]}; // least significant bit arrives first.
      end else if (bit_cnt == 4'd8) begin
        parity_bit <= data_sync;
      end else begin
        parity_err_q <= ~(^{parity_bit, shift});
        frame_err_q  <= ~data_sync;
      end
    end
  end

  assign rx.data       = shift;
  assign rx.valid      = valid_q;
  assign rx.parity_err = parity_err_q;
  assign rx.frame_err  = frame_err_q;

endmodule

`default_nettype wire

// File: rtl/ps2_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module ps2_tx (
  input  logic clk,
  input  logic rst,
  input  logic clk_fall,
  input  logic data_sync,
  output logic clk_drive_low,
  output logic data_drive_low,
  output logic busy
);

  localparam int CNT_W = $clog2(`PS2_INHIBIT_CYCLES);

  localparam logic [2:0] S_INIT    = 3'd0;
  localparam logic [2:0] S_INHIBIT = 3'd1;
  localparam logic [2:0] S_START   = 3'd2;
  localparam logic [2:0] S_DATA    = 3'd3;
  localparam logic [2:0] S_STOP    = 3'd4;
  localparam logic [2:0] S_DONE    = 3'd5;

  // eight data bits and odd parity, sent from bit 0 upward.
  localparam logic [8:0] FRAME = {~(^`PS2_CMD_ENABLE), `PS2_CMD_ENABLE};

  logic [2:0]       state;
  logic [CNT_W-1:0] count;
  logic [3:0]       bit_cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= S_INIT;
      count   <= '0;
      bit_cnt <= 4'd0;
    end else begin
      case (state)
        S_INIT: begin
          state <= S_INHIBIT;
          count <= CNT_W'(`PS2_INHIBIT_CYCLES - 1);
        end
        S_INHIBIT: begin
          if (count == '0) begin
            state <= S_START;
          end else begin
            count <= count - 1'b1;
          end
        end
        S_START: begin
          if (clk_fall) begin
            state   <= S_DATA;
            bit_cnt <= 4'd0;
          end
        end
        S_DATA: begin
          if (clk_fall) begin
            if (bit_cnt == 4'd8) begin
              state <= S_STOP;            // parity was the last bit driven.
            end else begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
        end
        S_STOP: begin
          // the device acknowledges by holding data low on this edge.
          if (clk_fall && !data_sync) begin
            state <= S_DONE;
          end
        end
        default: begin
          state <= S_DONE;
        end
      endcase
    end
  end

  assign clk_drive_low  = (state == S_INHIBIT);
  assign data_drive_low = (state == S_START) || ((state == S_DATA) && !FRAME[bit_cnt]);
  assign busy           = (state != S_DONE);

endmodule

`default_nettype wire

// File: rtl/mouse_packet.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module mouse_packet (
  input  logic                clk,
  input  logic                rst,
  ps2_byte_if.sink            rx,
  output logic                move_valid,
  output ps2_pkg::mouse_move_t move,
  output logic                enabled,
  output logic                byte_err
);

  ps2_pkg::mouse_byte_u in_byte;
  ps2_pkg::mouse_byte_u head;    // byte 0 of the packet in progress.
  logic [7:0]           dx_byte;
  logic [1:0]           pos;
  logic                 good;

  assign in_byte.raw = rx.data;
  assign good        = rx.valid & ~rx.parity_err & ~rx.frame_err;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos        <= 2'd0;
      enabled    <= 1'b0;
      byte_err   <= 1'b0;
      move_valid <= 1'b0;
    end else begin
      byte_err   <= rx.valid & ~good;
      move_valid <= 1'b0;
      if (rx.valid && !good) begin
        pos <= 2'd0;                       // a damaged byte restarts the packet.
      end else if (good) begin
        case (pos)
          2'd0: begin
            if (in_byte.raw == `PS2_ACK_BYTE) begin
              enabled <= 1'b1;
            end else if (in_byte.status.sync) begin
              pos <= 2'd1;
            end
          end
          2'd1: pos <= 2'd2;
          default: begin
            pos        <= 2'd0;
            move_valid <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (good && pos == 2'd0) head <= in_byte;
    if (good && pos == 2'd1) dx_byte <= in_byte.raw;
    if (good && pos == 2'd2) begin
      move.buttons <= {head.status.middle, head.status.right, head.status.left};
      move.dx <= head.status.x_ovf ? 9'd0 : {head.status.x_sign, dx_byte};
      move.dy <= head.status.y_ovf ? 9'd0 : {head.status.y_sign, in_byte.raw};
    end
  end

endmodule

`default_nettype wire

// File: rtl/mouse_tracker.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module mouse_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 move_valid,
  input  ps2_pkg::mouse_move_t move,
  input  logic                 recentre,
  output logic [8:0]           pos_x,
  output logic [8:0]           pos_y,
  output logic [2:0]           buttons
);

  logic signed [10:0] next_x;
  logic signed [10:0] next_y;

  function automatic logic [8:0] clamp(input logic signed [10:0] v, input logic [8:0] hi);
    if (v < 0) begin
      return 9'd0;
    end
    if (v > $signed({2'b00, hi})) begin
      return hi;
    end
    return v[8:0];
  endfunction

  // screen y grows downward, mouse y grows upward.
  assign next_x = $signed({2'b00, pos_x}) + move.dx;
  assign next_y = $signed({2'b00, pos_y}) - move.dy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos_x   <= `MOUSE_X_CENTER;
      pos_y   <= `MOUSE_Y_CENTER;
      buttons <= 3'd0;
    end else if (recentre) begin
      pos_x <= `MOUSE_X_CENTER;
      pos_y <= `MOUSE_Y_CENTER;
    end else if (move_valid) begin
      pos_x   <= clamp(next_x, `MOUSE_X_MAX);
      pos_y   <= clamp(next_y, `MOUSE_Y_MAX);
      buttons <= move.buttons;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ps2_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module ps2_apb_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  input  logic [2:0]  buttons,
  input  logic [8:0]  pos_x,
  input  logic [8:0]  pos_y,
  input  logic        enabled,
  input  logic        byte_err,
  output logic        recentre
);

  logic        access;
  logic        bad;
  logic        wr_ctrl;
  logic        err_clear;
  logic        err_sticky;
  logic [31:0] rd_word;

  assign access = psel & penable;

  // ***********************************************************************
  // register map. STATUS and the positions are read-only, CTRL is write-only.
  always_comb begin
    rd_word = 32'd0;
    bad     = 1'b0;
    case (paddr)
      `PS2_REG_STATUS: begin
        rd_word = {27'd0, err_sticky, enabled, buttons};
        bad     = pwrite;
      end
      `PS2_REG_POS_X: begin
        rd_word = {23'd0, pos_x};
        bad     = pwrite;
      end
      `PS2_REG_POS_Y: begin
        rd_word = {23'd0, pos_y};
        bad     = pwrite;
      end
      `PS2_REG_CTRL: bad = ~pwrite;
      default: bad = 1'b1;
    endcase
  end

  assign pslverr   = access & bad;
  assign prdata    = (access && !bad && !pwrite) ? rd_word : 32'd0;
  assign wr_ctrl   = access & pwrite & (paddr == `PS2_REG_CTRL);
  assign recentre  = wr_ctrl & pwdata[0];
  assign err_clear = wr_ctrl & pwdata[1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      err_sticky <= 1'b0;
    end else if (byte_err) begin
      err_sticky <= 1'b1;              // a new error beats a clear.
    end else if (err_clear) begin
      err_sticky <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ps2_mouse_top.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  inout  wire         ps2_clk,
  inout  wire         ps2_data
);

  logic                 clk_fall;
  logic                 data_sync;
  logic                 clk_drive_low;
  logic                 data_drive_low;
  logic                 busy;
  logic                 move_valid;
  ps2_pkg::mouse_move_t move;
  logic                 enabled;
  logic                 byte_err;
  logic                 recentre;
  logic [8:0]           pos_x;
  logic [8:0]           pos_y;
  logic [2:0]           buttons;

  ps2_byte_if byte_if ();

  // open-drain lines, pulled up outside the chip.
  assign ps2_clk  = clk_drive_low ? 1'b0 : 1'bz;
  assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

  ps2_rx u_rx (.clk(clk), .rst(rst), .ps2_clk_in(ps2_clk), .ps2_data_in(ps2_data),
               .hold(busy), .clk_fall(clk_fall), .data_sync(data_sync), .rx(byte_if.source));

  ps2_tx u_tx (.clk(clk), .rst(rst), .clk_fall(clk_fall), .data_sync(data_sync),
               .clk_drive_low(clk_drive_low), .data_drive_low(data_drive_low), .busy(busy));

  mouse_packet u_packet (.clk(clk), .rst(rst), .rx(byte_if.sink), .move_valid(move_valid),
                         .move(move), .enabled(enabled), .byte_err(byte_err));

  mouse_tracker u_tracker (.clk(clk), .rst(rst), .move_valid(move_valid), .move(move),
                           .recentre(recentre), .pos_x(pos_x), .pos_y(pos_y),
                           .buttons(buttons));

  ps2_apb_regs u_regs (.clk(clk), .rst(rst), .psel(psel), .penable(penable),
                       .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
                       .pslverr(pslverr), .buttons(buttons), .pos_x(pos_x), .pos_y(pos_y),
                       .enabled(enabled), .byte_err(byte_err), .recentre(recentre));

endmodule

`default_nettype wire

// File: bench/ps2_mouse_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module ps2_mouse_chk (
  input logic       clk,
  input logic       rst,
  input logic       psel,
  input logic       penable,
  input logic       pslverr,
  input logic       rx_valid,
  input logic [8:0] pos_x,
  input logic [8:0] pos_y,
  input logic       clk_drive_low
);

  int fail_count = 0; // read by the testbench at the end of the run.

  a_slverr_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> (psel && penable))
    else begin
      fail_count++;
      $error("pslverr high outside an APB access phase.");
    end

  a_valid_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else begin
      fail_count++;
      $error("receive valid held high for two cycles.");
    end

  a_pos_range: assert property (@(posedge clk) disable iff (rst)
    (pos_x <= `MOUSE_X_MAX) && (pos_y <= `MOUSE_Y_MAX))
    else begin
      fail_count++;
      $error("cursor position outside the screen rectangle.");
    end

  // the host holds the PS/2 clock low for exactly the inhibit time.
  a_inhibit_len: assert property (@(posedge clk) disable iff (rst)
    $fell(clk_drive_low) |->
      ($past(clk_drive_low, `PS2_INHIBIT_CYCLES) &&
       !$past(clk_drive_low, `PS2_INHIBIT_CYCLES + 1)))
    else begin
      fail_count++;
      $error("PS/2 clock inhibit did not last the configured number of cycles.");
    end

endmodule

bind ps2_mouse_top ps2_mouse_chk chk (
  .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pslverr(pslverr),
  .rx_valid(byte_if.valid), .pos_x(pos_x), .pos_y(pos_y),
  .clk_drive_low(clk_drive_low)
);

`default_nettype wire

// File: bench/ps2_mouse_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_config.svh"

module ps2_mouse_tb;

  localparam int HALF   = 20;  // device clock half period, in system clocks.
  localparam int N_ROWS = 9;
  localparam int N_RAND = 20;
  localparam int N_ENTRIES = N_ROWS + N_RAND + 4;
  localparam int WATCHDOG_NS = 2 * (`PS2_INHIBIT_CYCLES + N_ENTRIES * 33 * 2 * HALF) * 10;

  typedef struct packed {
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic       bad;   // corrupt the parity of the third byte.
    logic [2:0] btn;
  } row_t;

  logic clk, rst, psel, penable, pwrite, pslverr;
  logic [3:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic dev_clk_low, dev_data_low;
  wire  ps2_clk, ps2_data;
  row_t rows [N_ROWS];
  int   errors = 0;
  int   checks = 0;
  int   exp_x, exp_y;
  logic [2:0] exp_btn;
  logic exp_err;

  pullup (ps2_clk);
  pullup (ps2_data);
  assign ps2_clk  = dev_clk_low ? 1'b0 : 1'bz;
  assign ps2_data = dev_data_low ? 1'b0 : 1'bz;

  ps2_mouse_top UUT (.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
                     .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
                     .ps2_clk(ps2_clk), .ps2_data(ps2_data));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the run did not finish within its time limit");
    $display("Done: errors found");
    $finish;
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic int axis_delta(input logic sign, input logic ovf, input logic [7:0] b);
    if (ovf) return 0;
    return sign ? int'(b) - 256 : int'(b);
  endfunction

  function automatic int clamp_axis(input int v, input int hi);
    if (v < 0) return 0;
    if (v > hi) return hi;
    return v;
  endfunction

  // ***********************************************************************
  // APB master. Outputs are sampled on the falling edge of the access phase.
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] d;
    logic e;
    apb_access(1'b0, addr, 32'd0, d, e);
    check({what, " data"}, d, exp);
    check({what, " pslverr"}, e, 1'b0);
  endtask

  task automatic check_regs(input logic [2:0] btn);
    read_expect(`PS2_REG_STATUS, {27'd0, exp_err, 1'b1, btn}, "STATUS");
    read_expect(`PS2_REG_POS_X, exp_x, "POS_X");
    read_expect(`PS2_REG_POS_Y, exp_y, "POS_Y");
  endtask

  // ***********************************************************************
  // device model. Every step starts on a rising system clock edge.
  task automatic receive_command(output logic [8:0] frame, output logic stop);
    while (!(ps2_clk === 1'b1 && ps2_data === 1'b0)) @(posedge clk);
    repeat (HALF) @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      dev_clk_low <= 1'b1;
      repeat (HALF) @(posedge clk);
      dev_clk_low <= 1'b0;
      repeat (HALF) @(posedge clk);
      if (i < 9) frame[i] = ps2_data; // data, then parity.
      else stop = ps2_data;
    end
    dev_data_low <= 1'b1;             // line acknowledge.
    repeat (HALF) @(posedge clk);
    dev_clk_low <= 1'b1;
    repeat (HALF) @(posedge clk);
    dev_clk_low <= 1'b0;
    repeat (HALF) @(posedge clk);
    dev_data_low <= 1'b0;
    repeat (HALF) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic corrupt);
    logic [10:0] bits;
    bits = {1'b1, ~(^b) ^ corrupt, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      dev_data_low <= ~bits[i];
      repeat (HALF) @(posedge clk);
      dev_clk_low <= 1'b1;
      repeat (HALF) @(posedge clk);
      dev_clk_low <= 1'b0;
    end
    dev_data_low <= 1'b0;
    repeat (HALF) @(posedge clk);
  endtask

  task automatic send_packet(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
                             input logic bad);
    ps2_pkg::mouse_status_t st;
    st = b0;
    send_byte(b0, 1'b0);
    send_byte(b1, 1'b0);
    send_byte(b2, bad);
    if (bad) begin
      exp_err = 1'b1;                 // a damaged packet moves nothing.
    end else begin
      exp_x = clamp_axis(exp_x + axis_delta(st.x_sign, st.x_ovf, b1), `MOUSE_X_MAX);
      exp_y = clamp_axis(exp_y - axis_delta(st.y_sign, st.y_ovf, b2), `MOUSE_Y_MAX);
      exp_btn = {st.middle, st.right, st.left};
    end
  endtask

  initial begin
    logic [31:0] d;
    logic e;
    logic [8:0] frame;
    logic stop;
    logic [7:0] r0;
    int unsigned seed_val;
    seed_val = $urandom(32'h9c484aab);
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 4'd0;
    pwdata = 32'd0;
    dev_clk_low = 1'b0;
    dev_data_low = 1'b0;
    exp_x = `MOUSE_X_CENTER;
    exp_y = `MOUSE_Y_CENTER;
    exp_btn = 3'd0;
    exp_err = 1'b0;
    rows[0] = {8'h09, 8'd10, 8'd5, 1'b0, 3'b001};
    rows[1] = {8'h38, 8'hEC, 8'hE2, 1'b0, 3'b000};
    rows[2] = {8'h0A, 8'hFF, 8'h00, 1'b0, 3'b010}; // clamps at the x maximum.
    rows[3] = {8'h0C, 8'h64, 8'hC8, 1'b0, 3'b100}; // clamps at y zero.
    rows[4] = {8'h38, 8'h00, 8'h00, 1'b0, 3'b000};
    rows[5] = {8'h38, 8'h00, 8'h9C, 1'b0, 3'b000}; // x zero and y maximum.
    rows[6] = {8'h09, 8'h32, 8'h32, 1'b1, 3'b000};
    rows[7] = {8'h09, 8'h32, 8'h32, 1'b0, 3'b001};
    rows[8] = {8'h49, 8'h7F, 8'h0A, 1'b0, 3'b001}; // x overflow drops dx.
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // start-up: centre position, then the enable command and its acknowledge.
    read_expect(`PS2_REG_STATUS, 32'd0, "reset STATUS");
    read_expect(`PS2_REG_POS_X, `MOUSE_X_CENTER, "reset POS_X");
    read_expect(`PS2_REG_POS_Y, `MOUSE_Y_CENTER, "reset POS_Y");
    receive_command(frame, stop);
    check("command byte", frame[7:0], `PS2_CMD_ENABLE);
    check("command parity", ^frame, 1'b1);
    check("command stop bit", stop, 1'b1);
    send_byte(`PS2_ACK_BYTE, 1'b0);
    read_expect(`PS2_REG_STATUS, 32'h8, "enabled STATUS");

    for (int i = 0; i < N_ROWS; i++) begin
      send_packet(rows[i].b0, rows[i].b1, rows[i].b2, rows[i].bad);
      check_regs(rows[i].btn);
    end

    send_byte(8'h00, 1'b0);           // sync bit clear, so it is discarded.
    send_packet(8'h0A, 8'h05, 8'hFB, 1'b0);
    check_regs(exp_btn);

    // ***********************************************************************
    // register controls and bus errors.
    apb_access(1'b1, `PS2_REG_CTRL, 32'h1, d, e);
    exp_x = `MOUSE_X_CENTER;
    exp_y = `MOUSE_Y_CENTER;
    check_regs(exp_btn);
    apb_access(1'b1, `PS2_REG_CTRL, 32'h2, d, e);
    exp_err = 1'b0;
    check_regs(exp_btn);
    apb_access(1'b0, `PS2_REG_CTRL, 32'd0, d, e);
    check("CTRL read pslverr", e, 1'b1);
    check("CTRL read data", d, 32'd0);
    apb_access(1'b0, 4'h2, 32'd0, d, e);
    check("unmapped read pslverr", e, 1'b1);
    check("unmapped read data", d, 32'd0);
    apb_access(1'b1, `PS2_REG_POS_X, 32'd5, d, e);
    check("POS_X write pslverr", e, 1'b1);
    check_regs(exp_btn);

    for (int i = 0; i < N_RAND; i++) begin
      r0 = {2'b00, 2'($urandom), 1'b1, 3'($urandom)};
      send_packet(r0, 8'($urandom), 8'($urandom), 1'b0);
      check_regs(exp_btn);
    end

    $display("checks %0d, value errors %0d, assertion failures %0d",
             checks, errors, UUT.chk.fail_count);
    if (errors == 0 && UUT.chk.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/ps2_pkg.sv
rtl/ps2_byte_if.sv
rtl/ps2_rx.sv
rtl/ps2_tx.sv
rtl/mouse_packet.sv
rtl/mouse_tracker.sv
rtl/ps2_apb_regs.sv
rtl/ps2_mouse_top.sv
bench/ps2_mouse_chk.sv
bench/ps2_mouse_tb.sv

// File: Bender.yml
package:
  name: ps2_mouse

sources:
  - include_dirs:
      - include
    files:
      - rtl/ps2_pkg.sv
      - rtl/ps2_byte_if.sv
      - rtl/ps2_rx.sv
      - rtl/ps2_tx.sv
      - rtl/mouse_packet.sv
      - rtl/mouse_tracker.sv
      - rtl/ps2_apb_regs.sv
      - rtl/ps2_mouse_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/ps2_mouse_chk.sv
      - bench/ps2_mouse_tb.sv
